//--- hw/exec_pkg.sv
`default_nettype none

package exec_pkg;

	localparam int xlen = 64;

	// major opcode shared by all conditional branches
	localparam logic [6:0] opcode_branch = 7'b1100011;

	typedef enum logic [4:0] {
		op_add   = 5'd0,
		op_addw  = 5'd1,
		op_sll   = 5'd2,
		op_sllw  = 5'd3,
		op_sra   = 5'd4,
		op_sraw  = 5'd5,
		op_srl   = 5'd6,
		op_srlw  = 5'd7,
		op_and   = 5'd8,
		op_or    = 5'd9,
		op_xor   = 5'd10,
		op_slt   = 5'd11,
		op_sltu  = 5'd12,
		op_eq    = 5'd13,
		op_ne    = 5'd14,
		op_sge   = 5'd15,
		op_sgeu  = 5'd16,
		op_sub   = 5'd17,
		op_subw  = 5'd18,
		// 19 to 22 are the multiplies, not implemented
		op_div   = 5'd23,
		op_divu  = 5'd24,
		op_divw  = 5'd25,
		op_divuw = 5'd26,
		op_rem   = 5'd27,
		op_remu  = 5'd28,
		op_remuw = 5'd29,
		op_remw  = 5'd30
	} alu_op_e;

	typedef enum logic [1:0] {
		idle,
		div_run,
		div_done
	} div_state_e;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [31:0]     ins;
		alu_op_e         op;
		logic [xlen-1:0] src_a;
		logic [xlen-1:0] src_b;
		logic [xlen-1:0] rs2_data;
		logic [4:0]      rd;
		logic            reg_we;
		logic            mem_we;
		// 0 writes back the result, 1 the memory data
		logic            wb_sel_mem;
		logic            is_branch;
		logic [12:1]     bimm;
	} id_ex_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [31:0]     ins;
		logic [xlen-1:0] result;
		logic [xlen-1:0] rs2_data;
		logic [4:0]      rd;
		logic            reg_we;
		logic            mem_we;
		logic            wb_sel_mem;
	} ex_mem_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic            valid;
		logic [4:0]      rd;
		logic [xlen-1:0] data;
	} fwd_t;

	function automatic logic [xlen-1:0] sext_word(logic [31:0] w);
		return {{(xlen-32){w[31]}}, w};
	endfunction

	function automatic logic is_div_op(alu_op_e op);
		return op inside {op_div, op_divu, op_divw, op_divuw,
			op_rem, op_remu, op_remuw, op_remw};
	endfunction

	function automatic logic is_word_div_op(alu_op_e op);
		return op inside {op_divw, op_divuw, op_remuw, op_remw};
	endfunction

	function automatic logic is_signed_div_op(alu_op_e op);
		return op inside {op_div, op_divw, op_rem, op_remw};
	endfunction

	function automatic logic is_rem_op(alu_op_e op);
		return op inside {op_rem, op_remu, op_remuw, op_remw};
	endfunction

endpackage

`default_nettype wire

//--- hw/alu.sv
`default_nettype none

module alu import exec_pkg::*; (
	input  alu_op_e         op,
	input  logic [xlen-1:0] src_a,
	input  logic [xlen-1:0] src_b,
	output logic [xlen-1:0] result
);

	// 32-bit intermediate for the word operations
	logic [31:0] w;

	always_comb begin
		w = '0;
		result = '0;
		case (op)
			op_add: begin
				result = src_a + src_b;
			end
			op_addw: begin
				w = src_a[31:0] + src_b[31:0];
				result = sext_word(w);
			end
			op_sll: begin
				result = src_a << src_b[5:0];
			end
			op_sllw: begin
				w = src_a[31:0] << src_b[4:0];
				result = sext_word(w);
			end
			op_sra: begin
				result = $signed(src_a) >>> src_b[5:0];
			end
			op_sraw: begin
				w = $signed(src_a[31:0]) >>> src_b[4:0];
				result = sext_word(w);
			end
			op_srl: begin
				result = src_a >> src_b[5:0];
			end
			op_srlw: begin
				w = src_a[31:0] >> src_b[4:0];
				result = sext_word(w);
			end
			op_and: begin
				result = src_a & src_b;
			end
			op_or: begin
				result = src_a | src_b;
			end
			op_xor: begin
				result = src_a ^ src_b;
			end
			// comparisons give 0 or 1, branches test for nonzero
			op_slt: begin
				result = xlen'($signed(src_a) < $signed(src_b));
			end
			op_sltu: begin
				result = xlen'(src_a < src_b);
			end
			op_eq: begin
				result = xlen'(src_a == src_b);
			end
			op_ne: begin
				result = xlen'(src_a != src_b);
			end
			op_sge: begin
				result = xlen'($signed(src_a) >= $signed(src_b));
			end
			op_sgeu: begin
				result = xlen'(src_a >= src_b);
			end
			op_sub: begin
				result = src_a - src_b;
			end
			op_subw: begin
				w = src_a[31:0] - src_b[31:0];
				result = sext_word(w);
			end
			// multiplies, divides and unused codes read as zero here
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/div_datapath.sv
`default_nettype none

module div_datapath import exec_pkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  logic            start,
	input  logic            step,
	input  logic            finish,
	input  alu_op_e         op,
	input  logic [xlen-1:0] src_a,
	input  logic [xlen-1:0] src_b,
	output logic [xlen-1:0] quotient_rem
);

	alu_op_e op_q;
	logic neg_q_q;
	logic neg_r_q;
	logic div_zero_q;
	logic overflow_q;
	// dividend at op width, returned by the special cases
	logic [xlen-1:0] dividend_q;
	logic [xlen-1:0] divisor_q;
	logic [xlen-1:0] rem_q;
	logic [xlen-1:0] quo_q;

	logic word;
	logic signed_op;
	logic [xlen-1:0] a_ext;
	logic [xlen-1:0] b_ext;
	logic neg_a;
	logic neg_b;
	logic [xlen-1:0] abs_a;
	logic [xlen-1:0] abs_b;
	logic [xlen:0] rem_shift;
	logic [xlen:0] trial;
	logic [xlen-1:0] q_final;
	logic [xlen-1:0] r_final;
	logic [xlen-1:0] sel;

	// operands as values at the op width, signed or unsigned
	assign word = is_word_div_op(op);
	assign signed_op = is_signed_div_op(op);
	assign a_ext = !word ? src_a : signed_op ? sext_word(src_a[31:0]) : {32'b0, src_a[31:0]};
	assign b_ext = !word ? src_b : signed_op ? sext_word(src_b[31:0]) : {32'b0, src_b[31:0]};
	assign neg_a = signed_op & a_ext[xlen-1];
	assign neg_b = signed_op & b_ext[xlen-1];
	assign abs_a = neg_a ? -a_ext : a_ext;
	assign abs_b = neg_b ? -b_ext : b_ext;

	always_ff @(posedge clk) begin
		if (reset) begin
			op_q <= op_add;
			neg_q_q <= 1'b0;
			neg_r_q <= 1'b0;
			div_zero_q <= 1'b0;
			overflow_q <= 1'b0;
		end else if (start) begin
			op_q <= op;
			neg_q_q <= neg_a ^ neg_b;
			neg_r_q <= neg_a;
			div_zero_q <= b_ext == '0;
			overflow_q <= signed_op && b_ext == '1 &&
				a_ext == (word ? sext_word(32'h8000_0000) : {1'b1, {(xlen-1){1'b0}}});
		end
	end

	// one restoring step: shift in the next dividend bit, subtract if it fits
	assign rem_shift = {rem_q, quo_q[xlen-1]};
	assign trial = rem_shift - {1'b0, divisor_q};

	always_ff @(posedge clk) begin
		if (start) begin
			rem_q <= '0;
			// word dividend sits in the top half so 32 steps consume it
			quo_q <= word ? {abs_a[31:0], 32'b0} : abs_a;
			divisor_q <= abs_b;
			dividend_q <= a_ext;
		end else if (step) begin
			if (!trial[xlen]) begin
				rem_q <= trial[xlen-1:0];
				quo_q <= {quo_q[xlen-2:0], 1'b1};
			end else begin
				rem_q <= rem_shift[xlen-1:0];
				quo_q <= {quo_q[xlen-2:0], 1'b0};
			end
		end
	end

	always_comb begin
		if (div_zero_q) begin
			q_final = '1;
			r_final = dividend_q;
		end else if (overflow_q) begin
			q_final = dividend_q;
			r_final = '0;
		end else begin
			q_final = neg_q_q ? -quo_q : quo_q;
			r_final = neg_r_q ? -rem_q : rem_q;
		end
		sel = is_rem_op(op_q) ? r_final : q_final;
	end

	// result is presented only in the finishing cycle
	assign quotient_rem = !finish ? '0 : is_word_div_op(op_q) ? sext_word(sel[31:0]) : sel;

endmodule

`default_nettype wire

//--- hw/iter_counter.sv
`default_nettype none

module iter_counter #(
	parameter int width = 7
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             load,
	input  logic [width-1:0] load_value,
	output logic             last
);

	logic [width-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (load) begin
			count <= load_value;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// one left means the step in progress is the final one
	assign last = count == width'(1);

endmodule

`default_nettype wire

//--- hw/ex_ctrl.sv
`default_nettype none

module ex_ctrl import exec_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    in_valid,
	input  logic    out_ready,
	input  alu_op_e op,
	input  logic    iter_last,
	output logic    in_ready,
	output logic    accept,
	output logic    div_start,
	output logic    div_step,
	output logic    div_finish,
	output logic    counter_load,
	output logic    out_load,
	output logic    out_valid
);

	div_state_e state;
	div_state_e state_next;
	logic is_div;
	logic out_free;

	assign is_div = is_div_op(op);

	// output register is empty or drains on this edge
	assign out_free = !out_valid || out_ready;

	assign in_ready = state == idle && out_free;
	assign accept = in_valid && in_ready;
	assign div_start = accept && is_div;
	assign counter_load = div_start;
	assign div_step = state == div_run;
	assign div_finish = state == div_done;
	// the register is always empty by div_done, nothing loads it during a divide
	assign out_load = (accept && !is_div) || state == div_done;

	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				if (div_start) begin
					state_next = div_run;
				end
			end
			div_run: begin
				if (iter_last) begin
					state_next = div_done;
				end
			end
			div_done: begin
				state_next = idle;
			end
			default: begin
				state_next = idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (out_load) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hw/ex_result_stage.sv
`default_nettype none

module ex_result_stage import exec_pkg::*; (
	input  logic            clk,
	input  logic            reset,
	input  logic            in_valid,
	input  logic            accept,
	input  logic            out_load,
	input  logic            div_start,
	input  id_ex_t          id_ex,
	input  logic [xlen-1:0] alu_result,
	input  logic [xlen-1:0] div_result,
	output ex_mem_t         ex_mem,
	output redirect_t       redirect,
	output logic            bubble,
	output fwd_t            fwd
);

	// decode moves on after the handshake, so a divide keeps its own copy
	id_ex_t pend_q;
	id_ex_t src;
	logic [xlen-1:0] res;
	ex_mem_t ex_mem_d;

	always_ff @(posedge clk) begin
		if (div_start) begin
			pend_q <= id_ex;
		end
	end

	// a load in the accepting cycle is an ALU op, otherwise a divide finishing
	assign src = accept ? id_ex : pend_q;
	assign res = accept ? alu_result : div_result;

	always_comb begin
		ex_mem_d.pc = src.pc;
		ex_mem_d.ins = src.ins;
		ex_mem_d.result = res;
		ex_mem_d.rs2_data = src.rs2_data;
		ex_mem_d.rd = src.rd;
		ex_mem_d.reg_we = src.reg_we;
		ex_mem_d.mem_we = src.mem_we;
		ex_mem_d.wb_sel_mem = src.wb_sel_mem;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_mem.reg_we <= 1'b0;
			ex_mem.mem_we <= 1'b0;
		end else if (out_load) begin
			ex_mem <= ex_mem_d;
		end
	end

	// taken when the comparison result is nonzero
	assign redirect.valid = accept && id_ex.is_branch && alu_result != '0;
	assign redirect.target = id_ex.pc + {{(xlen-13){id_ex.bimm[12]}}, id_ex.bimm, 1'b0};

	assign bubble = in_valid && id_ex.ins[6:0] == opcode_branch;

	// divide results are not known yet, so they are not forwarded
	assign fwd.valid = in_valid && id_ex.reg_we && !is_div_op(id_ex.op);
	assign fwd.rd = id_ex.rd;
	assign fwd.data = alu_result;

endmodule

`default_nettype wire

//--- hw/exec_unit.sv
`default_nettype none

module exec_unit import exec_pkg::*; #(
	parameter int iter_width = 7
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      in_valid,
	input  id_ex_t    id_ex,
	input  logic      out_ready,
	output logic      in_ready,
	output logic      out_valid,
	output ex_mem_t   ex_mem,
	output redirect_t redirect,
	output logic      bubble,
	output fwd_t      fwd
);

	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] div_result;
	logic accept;
	logic div_start;
	logic div_step;
	logic div_finish;
	logic counter_load;
	logic out_load;
	logic iter_last;
	logic [iter_width-1:0] iter_load_value;

	// word divides need half the steps
	assign iter_load_value = is_word_div_op(id_ex.op) ? iter_width'(32) : iter_width'(xlen);

	alu u_alu (
		.op     (id_ex.op),
		.src_a  (id_ex.src_a),
		.src_b  (id_ex.src_b),
		.result (alu_result)
	);

	div_datapath u_div (
		.clk          (clk),
		.reset        (reset),
		.start        (div_start),
		.step         (div_step),
		.finish       (div_finish),
		.op           (id_ex.op),
		.src_a        (id_ex.src_a),
		.src_b        (id_ex.src_b),
		.quotient_rem (div_result)
	);

	iter_counter #(
		.width (iter_width)
	) u_iter (
		.clk        (clk),
		.reset      (reset),
		.load       (counter_load),
		.load_value (iter_load_value),
		.last       (iter_last)
	);

	ex_ctrl u_ctrl (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.out_ready    (out_ready),
		.op           (id_ex.op),
		.iter_last    (iter_last),
		.in_ready     (in_ready),
		.accept       (accept),
		.div_start    (div_start),
		.div_step     (div_step),
		.div_finish   (div_finish),
		.counter_load (counter_load),
		.out_load     (out_load),
		.out_valid    (out_valid)
	);

	ex_result_stage u_result (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.accept     (accept),
		.out_load   (out_load),
		.div_start  (div_start),
		.id_ex      (id_ex),
		.alu_result (alu_result),
		.div_result (div_result),
		.ex_mem     (ex_mem),
		.redirect   (redirect),
		.bubble     (bubble),
		.fwd        (fwd)
	);

endmodule

`default_nettype wire

//--- bench/tb_exec_unit.sv
`default_nettype none

module tb_exec_unit import exec_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int period = 4;
	localparam int max_instr = 400;
	localparam int max_cycles = 70;
	localparam int timeout_ns = max_instr * max_cycles * period;
	localparam int bp_count = 100;
	localparam logic [6:0] branch_opcode = 7'b1100011;

	logic clk;
	logic reset;
	logic in_valid;
	logic out_ready;
	id_ex_t id_ex;
	logic in_ready;
	logic out_valid;
	ex_mem_t ex_mem;
	redirect_t redirect;
	logic bubble;
	fwd_t fwd;

	int errors;
	int checks;
	int tests;
	ex_mem_t exp_q[$];

	exec_unit #(
		.iter_width (7)
	) UUT (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.id_ex     (id_ex),
		.out_ready (out_ready),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.ex_mem    (ex_mem),
		.redirect  (redirect),
		.bubble    (bubble),
		.fwd       (fwd)
	);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		#(timeout_ns);
		$display("Timeout: the tests did not finish within %0d ns", timeout_ns);
		$display("Simulation failed");
		$finish;
	end

	function automatic logic [63:0] rand64();
		return {$urandom, $urandom};
	endfunction

	function automatic logic [63:0] widen_word(logic [31:0] w);
		return {{32{w[31]}}, w};
	endfunction

	function automatic logic is_divide(alu_op_e op);
		return op >= op_div && op <= op_remw;
	endfunction

	function automatic logic [63:0] model_alu(alu_op_e op, logic [63:0] a, logic [63:0] b);
		logic [31:0] w;
		logic [63:0] r;
		w = '0;
		r = '0;
		case (op)
			op_add:  r = a + b;
			op_addw: r = widen_word(a[31:0] + b[31:0]);
			op_sll:  r = a << b[5:0];
			op_sllw: r = widen_word(a[31:0] << b[4:0]);
			op_sra:  r = $signed(a) >>> b[5:0];
			op_sraw: begin
				w = $signed(a[31:0]) >>> b[4:0];
				r = widen_word(w);
			end
			op_srl:  r = a >> b[5:0];
			op_srlw: r = widen_word(a[31:0] >> b[4:0]);
			op_and:  r = a & b;
			op_or:   r = a | b;
			op_xor:  r = a ^ b;
			op_slt:  r = {63'b0, $signed(a) < $signed(b)};
			op_sltu: r = {63'b0, a < b};
			op_eq:   r = {63'b0, a == b};
			op_ne:   r = {63'b0, a != b};
			op_sge:  r = {63'b0, $signed(a) >= $signed(b)};
			op_sgeu: r = {63'b0, a >= b};
			op_sub:  r = a - b;
			op_subw: r = widen_word(a[31:0] - b[31:0]);
			default: r = '0;
		endcase
		return r;
	endfunction

	// zero divisor and signed overflow follow the RISC-V rules and are handled first
	function automatic logic [63:0] model_div(alu_op_e op, logic [63:0] a, logic [63:0] b);
		logic sgn;
		logic word;
		logic rem;
		logic [63:0] q;
		logic [63:0] rm;
		logic [31:0] qw;
		logic [31:0] rw;
		sgn = op inside {op_div, op_rem, op_divw, op_remw};
		word = op inside {op_divw, op_divuw, op_remw, op_remuw};
		rem = op inside {op_rem, op_remu, op_remw, op_remuw};
		if (!word) begin
			if (b == '0) begin
				q = '1;
				rm = a;
			end else if (sgn && a == {1'b1, 63'b0} && b == '1) begin
				q = a;
				rm = '0;
			end else if (sgn) begin
				q = $signed(a) / $signed(b);
				rm = $signed(a) % $signed(b);
			end else begin
				q = a / b;
				rm = a % b;
			end
		end else begin
			if (b[31:0] == '0) begin
				qw = '1;
				rw = a[31:0];
			end else if (sgn && a[31:0] == 32'h8000_0000 && b[31:0] == '1) begin
				qw = a[31:0];
				rw = '0;
			end else if (sgn) begin
				qw = $signed(a[31:0]) / $signed(b[31:0]);
				rw = $signed(a[31:0]) % $signed(b[31:0]);
			end else begin
				qw = a[31:0] / b[31:0];
				rw = a[31:0] % b[31:0];
			end
			q = widen_word(qw);
			rm = widen_word(rw);
		end
		return rem ? rm : q;
	endfunction

	function automatic id_ex_t make_instr(alu_op_e op, logic [63:0] a, logic [63:0] b);
		id_ex_t d;
		d.pc = rand64() & ~64'd3;
		d.ins = $urandom;
		// register-register opcode gives no bubble unless a test changes it
		d.ins[6:0] = 7'b0110011;
		d.op = op;
		d.src_a = a;
		d.src_b = b;
		d.rs2_data = rand64();
		d.rd = 5'($urandom % 31 + 1);
		d.reg_we = 1'b1;
		d.mem_we = 1'($urandom % 2);
		d.wb_sel_mem = 1'($urandom % 2);
		d.is_branch = 1'b0;
		d.bimm = 12'($urandom);
		return d;
	endfunction

	function automatic ex_mem_t expect_out(id_ex_t d);
		ex_mem_t e;
		e.pc = d.pc;
		e.ins = d.ins;
		if (is_divide(d.op)) begin
			e.result = model_div(d.op, d.src_a, d.src_b);
		end else begin
			e.result = model_alu(d.op, d.src_a, d.src_b);
		end
		e.rs2_data = d.rs2_data;
		e.rd = d.rd;
		e.reg_we = d.reg_we;
		e.mem_we = d.mem_we;
		e.wb_sel_mem = d.wb_sel_mem;
		return e;
	endfunction

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_out(input ex_mem_t got, input ex_mem_t exp);
		check(got.result, exp.result, "ex_mem result");
		check(got.pc, exp.pc, "ex_mem pc");
		check(got.ins, exp.ins, "ex_mem ins");
		check(got.rs2_data, exp.rs2_data, "ex_mem rs2_data");
		check(got.rd, exp.rd, "ex_mem rd");
		check({got.reg_we, got.mem_we, got.wb_sel_mem},
			{exp.reg_we, exp.mem_we, exp.wb_sel_mem}, "ex_mem control bits");
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests++;
		$display("%s %s", name, errors == start_errors ? "ok" : "had errors");
	endtask

	// drives one instruction and returns after the edge that accepts it
	task automatic issue(input id_ex_t d);
		logic [63:0] alu_exp;
		logic [63:0] target_exp;
		logic fwd_exp;
		alu_exp = model_alu(d.op, d.src_a, d.src_b);
		target_exp = d.pc + 64'($signed({d.bimm, 1'b0}));
		fwd_exp = d.reg_we && !is_divide(d.op);
		@(negedge clk);
		in_valid = 1'b1;
		id_ex = d;
		#1;
		while (!in_ready) begin
			// a waiting branch must not redirect before it is taken
			check(redirect.valid, 1'b0, "redirect valid while stalled");
			check(bubble, d.ins[6:0] == branch_opcode, "bubble while stalled");
			@(negedge clk);
			#1;
		end
		check(redirect.valid, d.is_branch && alu_exp != '0, "redirect valid");
		check(redirect.target, target_exp, "redirect target");
		check(bubble, d.ins[6:0] == branch_opcode, "bubble");
		check(fwd.valid, fwd_exp, "fwd valid");
		if (fwd_exp) begin
			check(fwd.rd, d.rd, "fwd rd");
			check(fwd.data, alu_exp, "fwd data");
		end
		@(posedge clk);
	endtask

	// latency counts the accepting edge as the first cycle
	task automatic run_single(input id_ex_t d, input int exp_lat);
		ex_mem_t exp_out;
		int lat;
		exp_out = expect_out(d);
		issue(d);
		@(negedge clk);
		in_valid = 1'b0;
		#1;
		lat = 1;
		while (!out_valid && lat <= max_cycles) begin
			check(in_ready, 1'b0, "in_ready while busy");
			@(negedge clk);
			#1;
			lat++;
		end
		check(lat, exp_lat, "latency");
		compare_out(ex_mem, exp_out);
	endtask

	task automatic reset_values();
		int start;
		start = errors;
		#1;
		check(out_valid, 1'b0, "out_valid after reset");
		check(redirect.valid, 1'b0, "redirect valid after reset");
		check(fwd.valid, 1'b0, "fwd valid after reset");
		check(in_ready, 1'b1, "in_ready after reset");
		finish_test("reset state", start);
	endtask

	task automatic alu_ops();
		int i;
		int k;
		int start;
		logic [63:0] a;
		logic [63:0] b;
		start = errors;
		for (i = 0; i <= 18; i++) begin
			for (k = 0; k < 8; k++) begin
				a = rand64();
				b = k == 0 ? a : rand64();
				run_single(make_instr(alu_op_e'(i), a, b), 1);
			end
		end
		finish_test("alu operations", start);
	endtask

	task automatic div_ops();
		int i;
		int k;
		int start;
		alu_op_e op;
		logic word;
		logic [63:0] a;
		logic [63:0] b;
		start = errors;
		for (i = 23; i <= 30; i++) begin
			op = alu_op_e'(i);
			word = op inside {op_divw, op_divuw, op_remuw, op_remw};
			for (k = 0; k < 6; k++) begin
				a = rand64();
				b = rand64();
				case (k)
					1: b = b >> (32 + $urandom % 28);
					2: begin
						a = -(a >> 8);
						b = -(b >> 50);
					end
					3: a = a >> 40;
					// zero divisor where a word operand keeps a nonzero upper half
					4: b = word ? {b[63:32], 32'h0} : '0;
					5: begin
						a = word ? {a[63:32], 32'h8000_0000} : {1'b1, 63'b0};
						b = word ? {b[63:32], 32'hffff_ffff} : '1;
					end
					default: begin
					end
				endcase
				run_single(make_instr(op, a, b), word ? 34 : 66);
			end
		end
		finish_test("division", start);
	endtask

	task automatic branch_ops();
		alu_op_e cmp_ops [6];
		id_ex_t d;
		int i;
		int k;
		int start;
		logic [63:0] a;
		logic [63:0] b;
		start = errors;
		cmp_ops = '{op_eq, op_ne, op_slt, op_sltu, op_sge, op_sgeu};
		for (i = 0; i < 6; i++) begin
			for (k = 0; k < 6; k++) begin
				a = rand64();
				b = k % 2 == 0 ? a : rand64();
				d = make_instr(cmp_ops[i], a, b);
				d.ins[6:0] = branch_opcode;
				d.is_branch = 1'b1;
				d.reg_we = 1'b0;
				run_single(d, 1);
			end
		end
		// branch opcode with is_branch clear asks for a bubble but never redirects
		d = make_instr(op_eq, a, a);
		d.ins[6:0] = branch_opcode;
		run_single(d, 1);
		finish_test("branches", start);
	endtask

	task automatic stall_stream();
		int i;
		int start;
		int received;
		alu_op_e op;
		id_ex_t d;
		ex_mem_t held;
		ex_mem_t exp_out;
		logic holding;
		start = errors;
		fork
			begin
				for (i = 0; i < bp_count; i++) begin
					if ($urandom % 10 < 3) begin
						op = alu_op_e'(23 + $urandom % 8);
					end else begin
						op = alu_op_e'($urandom % 19);
					end
					d = make_instr(op, rand64(), rand64());
					// some comparisons go down the pipe as branches
					if (op >= op_slt && op <= op_sgeu && $urandom % 2 == 0) begin
						d.ins[6:0] = branch_opcode;
						d.is_branch = 1'b1;
						d.reg_we = 1'b0;
					end
					exp_q.push_back(expect_out(d));
					issue(d);
					if ($urandom % 4 == 0) begin
						@(negedge clk);
						in_valid = 1'b0;
					end
				end
				@(negedge clk);
				in_valid = 1'b0;
			end
			begin
				received = 0;
				holding = 1'b0;
				while (received < bp_count) begin
					@(negedge clk);
					out_ready = $urandom % 3 != 0;
					#1;
					// a stalled output must not change until it is taken
					if (holding) begin
						check(out_valid, 1'b1, "out_valid under back-pressure");
						check(ex_mem == held, 1'b1, "ex_mem stable under back-pressure");
					end
					holding = out_valid && !out_ready;
					held = ex_mem;
					if (out_valid && out_ready) begin
						if (exp_q.size() == 0) begin
							errors++;
							$display("The DUT delivered an extra result at %0t", $time);
						end else begin
							exp_out = exp_q.pop_front();
							compare_out(ex_mem, exp_out);
						end
						received++;
					end
				end
			end
		join
		@(negedge clk);
		out_ready = 1'b1;
		finish_test("back-pressure", start);
	endtask

	initial begin
		void'($urandom(79982));
		errors = 0;
		checks = 0;
		tests = 0;
		reset = 1'b1;
		in_valid = 1'b0;
		out_ready = 1'b1;
		id_ex = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		reset_values();
		alu_ops();
		div_ops();
		branch_ops();
		stall_stream();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
hw/exec_pkg.sv
hw/alu.sv
hw/div_datapath.sv
hw/iter_counter.sv
hw/ex_ctrl.sv
hw/ex_result_stage.sv
hw/exec_unit.sv
bench/tb_exec_unit.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
verilator --binary --timing -Wno-fatal --top-module tb_exec_unit -f src.f \
	-Mdir obj_dir -o sim_exec_unit > build.log 2>&1 \
	&& ./obj_dir/sim_exec_unit > sim.log 2>&1 \
	|| { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "^Simulation passed$" sim.log \
	&& echo "run_sim: pass line found" \
	|| { echo "run_sim: pass line missing"; exit 1; }
